/* src/lsu_consts.svh */
`ifndef LSU_CONSTS_SVH
`define LSU_CONSTS_SVH

//////////////////////////////
// Data path widths
//////////////////////////////

// One word of data and address
`define LSU_DATA_W 32

// Byte lanes per word
`define LSU_BE_W 4

//////////////////////////////
// Performance counters
//////////////////////////////

`define LSU_CNT_W 16

// Read select codes, code 3 is unused
`define LSU_CNT_LOAD  2'd0
`define LSU_CNT_STORE 2'd1
`define LSU_CNT_ERR   2'd2

`endif

/* src/lsu_pkg.sv */
`default_nettype none

`include "lsu_consts.svh"

package lsu_pkg;

  // Data and address words
  typedef logic [`LSU_DATA_W-1:0] word_t;
  typedef logic [`LSU_DATA_W-1:0] addr_t;

  // One enable per byte lane
  typedef logic [`LSU_BE_W-1:0] be_t;

  // Access size
  typedef enum logic [1:0] {
    DT_WORD = 2'b00,
    DT_HALF = 2'b01,
    DT_BYTE = 2'b10
  } data_type_e;

  // Bus sequencer states
  typedef enum logic [1:0] {
    IDLE = 2'b00,
    REQ  = 2'b01,
    RESP = 2'b10,
    DONE = 2'b11
  } lsu_state_e;

endpackage

`default_nettype wire

/* src/perf_pkg.sv */
`default_nettype none

`include "lsu_consts.svh"

package perf_pkg;

  // Counter value, wraps on overflow
  typedef logic [`LSU_CNT_W-1:0] cnt_t;

  // Counter read select
  typedef enum logic [1:0] {
    CNT_LOAD  = `LSU_CNT_LOAD,
    CNT_STORE = `LSU_CNT_STORE,
    CNT_ERR   = `LSU_CNT_ERR
  } cnt_sel_e;

endpackage

`default_nettype wire

/* src/lsu_align_if.sv */
`timescale 1ns/1ns
`default_nettype none

interface lsu_align_if
  import lsu_pkg::*;
();

  // Access description from the sequencer
  data_type_e data_type;
  logic [1:0] offset;
  logic       sign_ext;
  word_t      wdata;
  word_t      rdata_raw;

  // Lane results from the aligner
  be_t        be;
  word_t      wdata_shifted;
  word_t      rdata_ext;
  logic       misaligned;

  modport requester (
    output data_type, offset, sign_ext, wdata, rdata_raw,
    input  be, wdata_shifted, rdata_ext, misaligned
  );

  modport aligner (
    input  data_type, offset, sign_ext, wdata, rdata_raw,
    output be, wdata_shifted, rdata_ext, misaligned
  );

endinterface

`default_nettype wire

/* src/lsu_event_if.sv */
`timescale 1ns/1ns
`default_nettype none

interface lsu_event_if;

  // One-cycle completion strobes, at most one high per cycle
  logic load_done;
  logic store_done;
  logic err_done;

  modport source (
    output load_done, store_done, err_done
  );

  modport sink (
    input load_done, store_done, err_done
  );

endinterface

`default_nettype wire

/* src/lsu_align.sv */
`timescale 1ns/1ns
`default_nettype none

`include "lsu_consts.svh"

module lsu_align
  import lsu_pkg::*;
(
  lsu_align_if.aligner align
);

  word_t rdata_shift;

  //////////////////////////////
  // Write side
  //////////////////////////////

  always_comb begin
    case (align.data_type)
      DT_WORD: begin
        align.be = '1;
      end
      DT_HALF: begin
        align.be = align.offset[1] ? be_t'(4'b1100) : be_t'(4'b0011);
      end
      DT_BYTE: begin
        align.be = be_t'(1) << align.offset;
      end
      default: begin
        align.be = '0;
      end
    endcase
  end

  // Move write data up to the addressed lane
  assign align.wdata_shifted = align.wdata << {align.offset, 3'b000};

  // Half-words need an even offset, words a zero offset
  assign align.misaligned = ((align.data_type == DT_HALF) && align.offset[0]) ||
                            ((align.data_type == DT_WORD) && (align.offset != 2'b00));

  //////////////////////////////
  // Read side
  //////////////////////////////

  // Bring the addressed lane down to bit 0
  assign rdata_shift = align.rdata_raw >> {align.offset, 3'b000};

  always_comb begin
    case (align.data_type)
      DT_BYTE: begin
        align.rdata_ext = {{(`LSU_DATA_W-8){align.sign_ext & rdata_shift[7]}},
                           rdata_shift[7:0]};
      end
      DT_HALF: begin
        align.rdata_ext = {{(`LSU_DATA_W-16){align.sign_ext & rdata_shift[15]}},
                           rdata_shift[15:0]};
      end
      default: begin
        align.rdata_ext = rdata_shift;
      end
    endcase
  end

endmodule

`default_nettype wire

/* src/lsu_bus_fsm.sv */
`timescale 1ns/1ns
`default_nettype none

`include "lsu_consts.svh"

module lsu_bus_fsm
  import lsu_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_ni,

  // Request side
  input  logic        req_i,
  input  logic        we_i,
  input  data_type_e  type_i,
  input  logic        sign_ext_i,
  input  addr_t       addr_i,
  input  word_t       wdata_i,
  output logic        done_o,
  output word_t       rdata_o,
  output logic        err_o,
  output logic        busy_o,

  // Data bus
  output logic        data_req_o,
  input  logic        data_gnt_i,
  input  logic        data_rvalid_i,
  input  logic        data_err_i,
  input  word_t       data_rdata_i,
  output logic        data_we_o,
  output be_t         data_be_o,
  output addr_t       data_addr_o,
  output word_t       data_wdata_o,

  lsu_align_if.requester align,
  lsu_event_if.source    evt
);

  lsu_state_e state_q;
  lsu_state_e state_d;
  logic       accept;
  logic       resp_done;
  logic       we_q;
  data_type_e type_q;
  logic       sign_ext_q;
  addr_t      addr_q;
  word_t      wdata_q;
  word_t      rdata_q;
  logic       err_q;

  assign busy_o    = (state_q == REQ) || (state_q == RESP);
  assign accept    = req_i && !busy_o;
  assign resp_done = (state_q == RESP) && data_rvalid_i;

  // While not busy the aligner checks the incoming request
  assign align.data_type = busy_o ? type_q : type_i;
  assign align.offset    = busy_o ? addr_q[1:0] : addr_i[1:0];
  assign align.sign_ext  = sign_ext_q;
  assign align.wdata     = wdata_q;
  assign align.rdata_raw = data_rdata_i;

  //////////////////////////////
  // State machine
  //////////////////////////////

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE, DONE: begin
        if (accept) begin
          // Misaligned requests never reach the bus
          state_d = align.misaligned ? DONE : REQ;
        end else begin
          state_d = IDLE;
        end
      end
      REQ: begin
        if (data_gnt_i) begin
          state_d = RESP;
        end
      end
      RESP: begin
        if (data_rvalid_i) begin
          state_d = DONE;
        end
      end
      default: begin
        state_d = IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_i, negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= IDLE;
      err_q   <= 1'b0;
    end else begin
      state_q <= state_d;
      if (accept) begin
        err_q <= align.misaligned;
      end else if (resp_done) begin
        err_q <= data_err_i;
      end
    end
  end

  // Request and result payload
  always_ff @(posedge clk_i) begin
    if (accept) begin
      we_q       <= we_i;
      type_q     <= type_i;
      sign_ext_q <= sign_ext_i;
      addr_q     <= addr_i;
      wdata_q    <= wdata_i;
      rdata_q    <= '0;
    end else if (resp_done) begin
      rdata_q <= we_q ? '0 : align.rdata_ext;
    end
  end

  //////////////////////////////
  // Outputs
  //////////////////////////////

  assign data_req_o   = (state_q == REQ);
  assign data_we_o    = we_q;
  assign data_be_o    = align.be;
  assign data_addr_o  = {addr_q[`LSU_DATA_W-1:2], 2'b00};
  assign data_wdata_o = align.wdata_shifted;

  assign done_o  = (state_q == DONE);
  assign rdata_o = rdata_q;
  assign err_o   = err_q;

  // Exactly one strobe per completed access
  assign evt.err_done   = done_o && err_q;
  assign evt.load_done  = done_o && !err_q && !we_q;
  assign evt.store_done = done_o && !err_q && we_q;

endmodule

`default_nettype wire

/* src/perf_counters.sv */
`timescale 1ns/1ns
`default_nettype none

module perf_counters
  import perf_pkg::*;
(
  input  logic     clk_i,
  input  logic     rst_ni,

  lsu_event_if.sink evt,

  input  cnt_sel_e cnt_sel_i,
  input  logic     cnt_clr_i,
  output cnt_t     cnt_o
);

  cnt_t load_cnt_q;
  cnt_t store_cnt_q;
  cnt_t err_cnt_q;

  //////////////////////////////
  // Counters
  //////////////////////////////

  // Clear wins over a same-cycle event
  always_ff @(posedge clk_i, negedge rst_ni) begin
    if (!rst_ni) begin
      load_cnt_q  <= '0;
      store_cnt_q <= '0;
      err_cnt_q   <= '0;
    end else if (cnt_clr_i) begin
      load_cnt_q  <= '0;
      store_cnt_q <= '0;
      err_cnt_q   <= '0;
    end else begin
      if (evt.load_done) begin
        load_cnt_q <= load_cnt_q + 1'b1;
      end
      if (evt.store_done) begin
        store_cnt_q <= store_cnt_q + 1'b1;
      end
      if (evt.err_done) begin
        err_cnt_q <= err_cnt_q + 1'b1;
      end
    end
  end

  // Read port
  always_comb begin
    case (cnt_sel_i)
      CNT_LOAD: begin
        cnt_o = load_cnt_q;
      end
      CNT_STORE: begin
        cnt_o = store_cnt_q;
      end
      CNT_ERR: begin
        cnt_o = err_cnt_q;
      end
      default: begin
        cnt_o = '0;
      end
    endcase
  end

endmodule

`default_nettype wire

/* src/lsu_top.sv */
`timescale 1ns/1ns
`default_nettype none

module lsu_top
  import lsu_pkg::*;
  import perf_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_ni,

  // Request side
  input  logic        req_i,
  input  logic        we_i,
  input  data_type_e  type_i,
  input  logic        sign_ext_i,
  input  addr_t       addr_i,
  input  word_t       wdata_i,
  output logic        done_o,
  output word_t       rdata_o,
  output logic        err_o,
  output logic        busy_o,

  // Data bus
  output logic        data_req_o,
  input  logic        data_gnt_i,
  input  logic        data_rvalid_i,
  input  logic        data_err_i,
  input  word_t       data_rdata_i,
  output logic        data_we_o,
  output be_t         data_be_o,
  output addr_t       data_addr_o,
  output word_t       data_wdata_o,

  // Counter port
  input  logic [1:0]  cnt_sel_i,
  input  logic        cnt_clr_i,
  output cnt_t        cnt_o
);

  lsu_align_if i_align_if ();
  lsu_event_if i_event_if ();

  //////////////////////////////
  // Sequencer and aligner
  //////////////////////////////

  lsu_bus_fsm i_bus_fsm (
    .clk_i         ( clk_i         ),
    .rst_ni        ( rst_ni        ),
    .req_i         ( req_i         ),
    .we_i          ( we_i          ),
    .type_i        ( type_i        ),
    .sign_ext_i    ( sign_ext_i    ),
    .addr_i        ( addr_i        ),
    .wdata_i       ( wdata_i       ),
    .done_o        ( done_o        ),
    .rdata_o       ( rdata_o       ),
    .err_o         ( err_o         ),
    .busy_o        ( busy_o        ),
    .data_req_o    ( data_req_o    ),
    .data_gnt_i    ( data_gnt_i    ),
    .data_rvalid_i ( data_rvalid_i ),
    .data_err_i    ( data_err_i    ),
    .data_rdata_i  ( data_rdata_i  ),
    .data_we_o     ( data_we_o     ),
    .data_be_o     ( data_be_o     ),
    .data_addr_o   ( data_addr_o   ),
    .data_wdata_o  ( data_wdata_o  ),
    .align         ( i_align_if    ),
    .evt           ( i_event_if    )
  );

  lsu_align i_align (
    .align ( i_align_if )
  );

  //////////////////////////////
  // Counters
  //////////////////////////////

  perf_counters i_perf_counters (
    .clk_i     ( clk_i                  ),
    .rst_ni    ( rst_ni                 ),
    .evt       ( i_event_if             ),
    .cnt_sel_i ( cnt_sel_e'(cnt_sel_i)  ),
    .cnt_clr_i ( cnt_clr_i              ),
    .cnt_o     ( cnt_o                  )
  );

endmodule

`default_nettype wire

/* test/tb_lsu_top.sv */
`timescale 1ns/1ns
`default_nettype none

`include "lsu_consts.svh"

module tb_lsu_top
  import lsu_pkg::*;
  import perf_pkg::*;
();

  // About 80 accesses of at most 12 cycles each, plus counter reads and margin
  localparam int MAX_CYCLES = 2000;

  logic       clk_i;
  logic       rst_ni;
  logic       req_i;
  logic       we_i;
  data_type_e type_i;
  logic       sign_ext_i;
  addr_t      addr_i;
  word_t      wdata_i;
  logic       done_o;
  word_t      rdata_o;
  logic       err_o;
  logic       busy_o;
  logic       data_req_o;
  logic       data_gnt_i;
  logic       data_rvalid_i;
  logic       data_err_i;
  word_t      data_rdata_i;
  logic       data_we_o;
  be_t        data_be_o;
  addr_t      data_addr_o;
  word_t      data_wdata_o;
  logic [1:0] cnt_sel_i;
  logic       cnt_clr_i;
  cnt_t       cnt_o;

  integer     seed = 32'h6a26_bd4f;
  int         cycle_cnt = 0;
  string      test_name = "reset";

  // Bus memory and the reference copy
  logic [7:0] mem [0:4095];
  logic [7:0] ref_mem [0:4095];
  int         ref_load = 0;
  int         ref_store = 0;
  int         ref_err = 0;

  // Responder state
  int         gnt_wait = -1;
  int         rsp_wait;
  logic       rsp_pending = 1'b0;
  logic       rsp_err;
  word_t      rsp_data;

  lsu_top i_dut (.*);

  always #50 clk_i = ~clk_i;

  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= MAX_CYCLES) begin
      fail_run("Timeout, the run did not finish within the cycle limit");
    end
  end

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("Simulation FAILED");
    $fatal(1, "Run stopped");
  endtask

  task automatic check_value(input string what, input logic [31:0] exp, input logic [31:0] act);
    assert (act === exp) else begin
      fail_run($sformatf("Error %s, %s: expected %h, actual %h", test_name, what, exp, act));
    end
  endtask

  function automatic word_t mem_word(input int base);
    return {mem[base+3], mem[base+2], mem[base+1], mem[base]};
  endfunction

  function automatic word_t ref_word(input int base);
    return {ref_mem[base+3], ref_mem[base+2], ref_mem[base+1], ref_mem[base]};
  endfunction

  //////////////////////////////
  // Memory model
  //////////////////////////////

  always @(posedge clk_i) begin
    data_gnt_i    <= 1'b0;
    data_rvalid_i <= 1'b0;
    data_err_i    <= 1'b0;
    if (data_req_o && data_gnt_i) begin
      // Transfer taken at this edge
      gnt_wait    = -1;
      rsp_wait    = $unsigned($random(seed)) % 3;
      rsp_pending = 1'b1;
      rsp_err     = data_addr_o[12];
      rsp_data    = mem_word(data_addr_o[11:0]);
      if (!rsp_err && data_we_o) begin
        for (int k = 0; k < 4; k++) begin
          if (data_be_o[k]) begin
            mem[data_addr_o[11:0] + k] = data_wdata_o[8*k +: 8];
          end
        end
      end
    end else if (data_req_o) begin
      if (gnt_wait < 0) begin
        gnt_wait = $unsigned($random(seed)) % 4;
      end
      if (gnt_wait == 0) begin
        data_gnt_i <= 1'b1;
      end else begin
        gnt_wait = gnt_wait - 1;
      end
    end
    if (rsp_pending) begin
      if (rsp_wait == 0) begin
        data_rvalid_i <= 1'b1;
        data_err_i    <= rsp_err;
        data_rdata_i  <= rsp_data;
        rsp_pending = 1'b0;
      end else begin
        rsp_wait = rsp_wait - 1;
      end
    end
  end

  //////////////////////////////
  // Access with reference model
  //////////////////////////////

  task automatic run_access(input logic we, input data_type_e dt, input logic sext,
                            input addr_t addr, input word_t wdata);
    logic [1:0] off;
    logic       mis;
    logic       exp_err;
    logic       saw_req;
    int         base;
    be_t        exp_be;
    word_t      exp_wdata;
    word_t      exp_rdata;
    word_t      lane_mask;
    logic [7:0]  lane_b;
    logic [15:0] lane_h;
    off       = addr[1:0];
    mis       = ((dt == DT_HALF) && off[0]) || ((dt == DT_WORD) && (off != 2'b00));
    exp_err   = mis || addr[12];
    base      = addr[11:0] & 12'hffc;
    exp_wdata = wdata << (8 * off);
    exp_rdata = '0;
    case (dt)
      DT_BYTE: exp_be = 4'b0001 << off;
      DT_HALF: exp_be = 4'b0011 << off;
      default: exp_be = 4'b1111;
    endcase
    for (int k = 0; k < 4; k++) begin
      lane_mask[8*k +: 8] = {8{exp_be[k]}};
    end
    if (!mis) begin
      lane_b = ref_mem[base + off];
      lane_h = {ref_mem[base + off + 1], ref_mem[base + off]};
      case (dt)
        DT_BYTE: exp_rdata = {{24{sext & lane_b[7]}}, lane_b};
        DT_HALF: exp_rdata = {{16{sext & lane_h[15]}}, lane_h};
        default: exp_rdata = ref_word(base);
      endcase
    end
    @(posedge clk_i);
    req_i      <= 1'b1;
    we_i       <= we;
    type_i     <= dt;
    sign_ext_i <= sext;
    addr_i     <= addr;
    wdata_i    <= wdata;
    @(posedge clk_i);
    req_i   <= 1'b0;
    saw_req = 1'b0;
    @(posedge clk_i);
    check_value("busy_o after accept", !mis, busy_o);
    while (!done_o) begin
      if (data_req_o) begin
        saw_req = 1'b1;
        check_value("bus address", {addr[31:2], 2'b00}, data_addr_o);
        check_value("bus byte enables", exp_be, data_be_o);
        check_value("bus write enable", we, data_we_o);
        if (we) begin
          check_value("bus write data", exp_wdata & lane_mask, data_wdata_o & lane_mask);
        end
      end
      @(posedge clk_i);
    end
    check_value("bus request seen", !mis, saw_req);
    check_value("busy_o with done_o", 1'b0, busy_o);
    check_value("err_o", exp_err, err_o);
    if (!we && !exp_err) begin
      check_value("load data", exp_rdata, rdata_o);
    end
    // Reference update
    if (exp_err) begin
      ref_err++;
    end else if (we) begin
      ref_store++;
      for (int k = 0; k < 4; k++) begin
        if (exp_be[k]) begin
          ref_mem[base + k] = exp_wdata[8*k +: 8];
        end
      end
    end else begin
      ref_load++;
    end
    check_value("memory word", ref_word(base), mem_word(base));
  endtask

  task automatic read_counter(input logic [1:0] sel, input int exp, input string what);
    @(posedge clk_i);
    cnt_sel_i <= sel;
    @(posedge clk_i);
    check_value(what, exp[15:0], cnt_o);
  endtask

  task automatic check_counters();
    read_counter(`LSU_CNT_LOAD, ref_load, "load counter");
    read_counter(`LSU_CNT_STORE, ref_store, "store counter");
    read_counter(`LSU_CNT_ERR, ref_err, "error counter");
    read_counter(2'd3, 0, "unused select");
  endtask

  //////////////////////////////
  // Test sequence
  //////////////////////////////

  initial begin
    addr_t      a;
    data_type_e dt;
    clk_i         = 1'b0;
    rst_ni        = 1'b0;
    req_i         = 1'b0;
    we_i          = 1'b0;
    type_i        = DT_WORD;
    sign_ext_i    = 1'b0;
    addr_i        = '0;
    wdata_i       = '0;
    data_gnt_i    = 1'b0;
    data_rvalid_i = 1'b0;
    data_err_i    = 1'b0;
    data_rdata_i  = '0;
    cnt_sel_i     = 2'd0;
    cnt_clr_i     = 1'b0;
    for (int i = 0; i < 4096; i++) begin
      mem[i]     = i[7:0] ^ {i[11:8], i[11:8]};
      ref_mem[i] = mem[i];
    end
    repeat (3) @(posedge clk_i);
    rst_ni <= 1'b1;

    @(posedge clk_i);
    check_value("data_req_o", 1'b0, data_req_o);
    check_value("done_o", 1'b0, done_o);
    check_value("busy_o", 1'b0, busy_o);
    check_value("err_o", 1'b0, err_o);
    check_counters();

    test_name = "word store and load";
    a = $random(seed) & 32'h0000_0ffc;
    run_access(1'b1, DT_WORD, 1'b0, a, $random(seed));
    run_access(1'b0, DT_WORD, 1'b0, a, '0);

    test_name = "sub-word store and load";
    for (int off = 0; off < 4; off++) begin
      a = ($random(seed) & 32'h0000_0ffc) | off;
      run_access(1'b1, DT_BYTE, 1'b0, a, $random(seed) | 32'h0000_8080);
      run_access(1'b0, DT_BYTE, 1'b0, a, '0);
      run_access(1'b0, DT_BYTE, 1'b1, a, '0);
      if (!off[0]) begin
        run_access(1'b1, DT_HALF, 1'b0, a, $random(seed) | 32'h0000_8080);
        run_access(1'b0, DT_HALF, 1'b0, a, '0);
        run_access(1'b0, DT_HALF, 1'b1, a, '0);
      end
    end

    test_name = "misaligned access";
    for (int off = 1; off < 4; off++) begin
      a = ($random(seed) & 32'h0000_0ffc) | off;
      run_access(1'b1, DT_WORD, 1'b0, a, $random(seed));
      run_access(1'b0, DT_WORD, 1'b0, a, '0);
      if (off[0]) begin
        run_access(1'b1, DT_HALF, 1'b0, a, $random(seed));
      end
    end

    test_name = "bus error";
    a = ($random(seed) & 32'h0000_0ffc) | 32'h0000_1000;
    run_access(1'b1, DT_WORD, 1'b0, a, $random(seed));
    run_access(1'b0, DT_WORD, 1'b0, a, '0);

    test_name = "random mix";
    for (int n = 0; n < 50; n++) begin
      a  = $random(seed) & 32'h0000_0fff;
      dt = data_type_e'($unsigned($random(seed)) % 3);
      if (($unsigned($random(seed)) % 8) == 0) begin
        a[12] = 1'b1;
      end
      run_access($random(seed) & 1, dt, $random(seed) & 1, a, $random(seed));
    end
    check_counters();

    test_name = "counter clear";
    @(posedge clk_i);
    cnt_clr_i <= 1'b1;
    @(posedge clk_i);
    cnt_clr_i <= 1'b0;
    ref_load  = 0;
    ref_store = 0;
    ref_err   = 0;
    check_counters();

    $display("Simulation PASSED");
    $finish;
  end

endmodule

`default_nettype wire

/* project.f */
+incdir+src
src/lsu_pkg.sv
src/perf_pkg.sv
src/lsu_align_if.sv
src/lsu_event_if.sv
src/lsu_align.sv
src/lsu_bus_fsm.sv
src/perf_counters.sv
src/lsu_top.sv
test/tb_lsu_top.sv
